// File: Bender.yml
package:
  name: led_panel

export_include_dirs:
  - hdl

sources:
  - hdl/led_panel_pkg.sv
  - hdl/gamma_encoder.sv
  - hdl/line_buffer.sv
  - hdl/pwm_scan_engine.sv
  - hdl/led_panel_driver.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/led_panel_props.sv
      - dv/led_panel_tb.sv

// File: dv/led_panel_props.sv
`timescale 1ns/1ps
`include "led_panel_defines.svh"

module led_panel_props (
	input logic clk,
	input logic rst,
	input logic col_clk,
	input logic col_latch,
	input logic led_oe
);

	// panel clocks since the last latch
	int unsigned clk_pulses;
	// set once the first latch after reset has gone out
	logic latch_seen;
	// number of assertion failures so far
	int unsigned assert_fails = 0;

	always_ff @(posedge clk) begin
		if (rst) begin
			clk_pulses <= 0;
			latch_seen <= 1'b0;
		end else begin
			if (col_latch) begin
				clk_pulses <= 0;
				latch_seen <= 1'b1;
			end else if (col_clk) begin
				clk_pulses <= clk_pulses + 1;
			end
		end
	end

	// a latch transfers exactly one full row of shifted bits
	a_latch_after_cols: assert property (@(posedge clk) disable iff (rst)
		col_latch |-> clk_pulses == `LP_COLS)
		else begin
			$error("col_latch after %0d col_clk pulses", clk_pulses);
			assert_fails++;
		end

	// shifting and latching never overlap
	a_clk_latch_apart: assert property (@(posedge clk) disable iff (rst)
		!(col_clk && col_latch))
		else begin
			$error("col_clk and col_latch high together");
			assert_fails++;
		end

	// LEDs stay dark until the first latch, which is where they may come on
	a_oe_after_latch: assert property (@(posedge clk) disable iff (rst)
		(!latch_seen && !col_latch) |-> !led_oe)
		else begin
			$error("led_oe high before the first latch");
			assert_fails++;
		end

	// and every turn-on happens together with a latch
	a_oe_rises_on_latch: assert property (@(posedge clk) disable iff (rst)
		$rose(led_oe) |-> col_latch)
		else begin
			$error("led_oe rose outside a latch cycle");
			assert_fails++;
		end

endmodule

// File: dv/led_panel_tb.sv
`timescale 1ns/1ps
`include "led_panel_defines.svh"

module led_panel_tb;

	localparam int CLK_PERIOD = 40;
	localparam int DRV_DELAY = 2;
	localparam int NUM_TESTS = 6;
	localparam int NUM_PIX = NUM_TESTS * `LP_COLS;
	localparam int LVL_MAX = (1 << `LP_PWM_BITS) - 1;
	localparam int CHAN_MAX = (1 << `LP_CHAN_BITS) - 1;
	// one row costs its fill plus a shift and latch pass for every PWM step
	localparam int ROW_CYCLES = `LP_COLS + (`LP_COLS + 1) * (LVL_MAX + 1);
	localparam int MARGIN = 40;
	localparam int WATCHDOG_NS = (NUM_TESTS * (ROW_CYCLES + MARGIN) + 8) * CLK_PERIOD;

	typedef enum int {
		PAT_ZERO,
		PAT_FULL,
		PAT_RAMP,
		PAT_SINGLE,
		PAT_RANDOM,
		PAT_GAPS
	} pattern_e;

	typedef struct {
		string name;
		pattern_e kind;
		int exp_row;
	} test_t;

	// one entry per displayed row, in the order the rows are streamed in
	// the fifth row lands on address 0 again after the wrap
	test_t tests [NUM_TESTS] = '{
		'{"all_zero", PAT_ZERO, 0},
		'{"full_scale", PAT_FULL, 1},
		'{"ramp", PAT_RAMP, 2},
		'{"single_column", PAT_SINGLE, 3},
		'{"random", PAT_RANDOM, 0},
		'{"random_gaps", PAT_GAPS, 1}
	};

	logic clk;
	logic rst;
	logic pix_valid;
	logic pix_ready;
	led_panel_pkg::channel_t pix_r;
	led_panel_pkg::channel_t pix_g;
	led_panel_pkg::channel_t pix_b;
	led_panel_pkg::row_t row_addr;
	logic col_r;
	logic col_g;
	logic col_b;
	logic col_clk;
	logic col_latch;
	logic led_oe;

	// stimulus, idle cycles before each pixel and the levels we expect to see
	led_panel_pkg::channel_t stim_r [NUM_PIX];
	led_panel_pkg::channel_t stim_g [NUM_PIX];
	led_panel_pkg::channel_t stim_b [NUM_PIX];
	int gap [NUM_PIX];
	led_panel_pkg::level_t exp_r [NUM_PIX];
	led_panel_pkg::level_t exp_g [NUM_PIX];
	led_panel_pkg::level_t exp_b [NUM_PIX];

	int err_cnt;
	int pass_cnt;
	int fail_cnt;
	int rows_done;
	int mon_step;
	int shift_n;
	int accepted;
	logic [31:0] rng;
	logic [`LP_COLS-1:0] got_r;
	logic [`LP_COLS-1:0] got_g;
	logic [`LP_COLS-1:0] got_b;

	led_panel_driver dut0 (
		.clk(clk), .rst(rst),
		.pix_valid(pix_valid), .pix_ready(pix_ready),
		.pix_r(pix_r), .pix_g(pix_g), .pix_b(pix_b),
		.row_addr(row_addr),
		.col_r(col_r), .col_g(col_g), .col_b(col_b),
		.col_clk(col_clk), .col_latch(col_latch), .led_oe(led_oe)
	);

	// pin protocol assertions ride along on the DUT
	bind led_panel_driver led_panel_props props0 (
		.clk(clk), .rst(rst),
		.col_clk(col_clk), .col_latch(col_latch), .led_oe(led_oe)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// one 32-bit xorshift step whose state is kept by the caller
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// level = floor((x / channel max) ^ gamma * PWM max)
	function automatic led_panel_pkg::level_t ref_level(input int x);
		real frac;
		frac = real'(x) / real'(CHAN_MAX);
		return led_panel_pkg::level_t'(int'($floor($pow(frac, `LP_GAMMA) * real'(LVL_MAX))));
	endfunction

	// bits a colour should carry in one PWM step with bit c standing for column c
	function automatic logic [`LP_COLS-1:0] lit_mask(input int base, input int step,
			input int colour);
		logic [`LP_COLS-1:0] m;
		int lvl;
		for (int c = 0; c < `LP_COLS; c++) begin
			case (colour)
				0: lvl = exp_r[base + c];
				1: lvl = exp_g[base + c];
				default: lvl = exp_b[base + c];
			endcase
			m[c] = (lvl > step);
		end
		return m;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		if (exp_val !== act_val) begin
			$display("** Error %s: expected %0d, actual %0d", name, exp_val, act_val);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name, input int start_err);
		if (err_cnt == start_err) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d mismatches", name, err_cnt - start_err);
		end
	endtask

	// fill every row's pixels and their reference levels up front
	task automatic build_stimulus();
		int p;
		for (int t = 0; t < NUM_TESTS; t++) begin
			for (int c = 0; c < `LP_COLS; c++) begin
				p = t * `LP_COLS + c;
				gap[p] = 0;
				case (tests[t].kind)
					PAT_ZERO: begin
						stim_r[p] = '0;
						stim_g[p] = '0;
						stim_b[p] = '0;
					end
					PAT_FULL: begin
						stim_r[p] = CHAN_MAX;
						stim_g[p] = CHAN_MAX;
						stim_b[p] = CHAN_MAX;
					end
					PAT_RAMP: begin
						// red rises, green falls, blue rises on a different slope
						stim_r[p] = c * 36;
						stim_g[p] = CHAN_MAX - c * 36;
						stim_b[p] = c * 32 + 16;
					end
					PAT_SINGLE: begin
						stim_r[p] = (c == 5) ? CHAN_MAX : 0;
						stim_g[p] = (c == 5) ? CHAN_MAX : 0;
						stim_b[p] = (c == 5) ? CHAN_MAX : 0;
					end
					default: begin
						rng = xorshift(rng);
						stim_r[p] = rng[7:0];
						stim_g[p] = rng[15:8];
						stim_b[p] = rng[23:16];
						if (tests[t].kind == PAT_GAPS) begin
							gap[p] = rng[29:28] + 1;
						end
					end
				endcase
				exp_r[p] = ref_level(stim_r[p]);
				exp_g[p] = ref_level(stim_g[p]);
				exp_b[p] = ref_level(stim_b[p]);
			end
		end
	endtask

	// streams all rows back to back, so later rows pile up against the stall
	task automatic send_pixels();
		for (int p = 0; p < NUM_PIX; p++) begin
			if (gap[p] > 0) begin
				pix_valid = 1'b0;
				repeat (gap[p]) begin
					@(posedge clk);
					#DRV_DELAY;
				end
			end
			pix_valid = 1'b1;
			pix_r = stim_r[p];
			pix_g = stim_g[p];
			pix_b = stim_b[p];
			// data stays put until the handshake edge
			@(negedge clk);
			while (!pix_ready) @(negedge clk);
			@(posedge clk);
			#DRV_DELAY;
		end
		pix_valid = 1'b0;
	endtask

	// the panel monitor samples mid-cycle where every pin has settled
	always @(negedge clk) begin
		int base;
		if (rst === 1'b0) begin
			// at most one row in the buffer plus one pixel held in the encoder
			if (pix_valid && pix_ready) begin
				check_equal(tests[accepted / `LP_COLS].name, 1,
					accepted < (rows_done + 1) * `LP_COLS + 1);
				accepted++;
			end
			if (col_clk) begin
				got_r[shift_n] = col_r;
				got_g[shift_n] = col_g;
				got_b[shift_n] = col_b;
				shift_n++;
			end
			if (col_latch && rows_done < NUM_TESTS) begin
				base = rows_done * `LP_COLS;
				check_equal(tests[rows_done].name, lit_mask(base, mon_step, 0), got_r);
				check_equal(tests[rows_done].name, lit_mask(base, mon_step, 1), got_g);
				check_equal(tests[rows_done].name, lit_mask(base, mon_step, 2), got_b);
				check_equal(tests[rows_done].name, tests[rows_done].exp_row, row_addr);
				// LEDs are dark only in the release cycle of the last step
				check_equal(tests[rows_done].name, mon_step != LVL_MAX, led_oe);
				// the next row's pixels are already waiting, so input is stalled
				if (mon_step == 0 && rows_done < NUM_TESTS - 1) begin
					check_equal(tests[rows_done].name, 0, pix_ready);
				end
				shift_n = 0;
				got_r = '0;
				got_g = '0;
				got_b = '0;
				if (mon_step == LVL_MAX) begin
					mon_step = 0;
					rows_done++;
				end else begin
					mon_step++;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: the run timed out before every row was displayed");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int start_err;
		rst = 1'b1;
		pix_valid = 1'b0;
		pix_r = '0;
		pix_g = '0;
		pix_b = '0;
		err_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		rows_done = 0;
		mon_step = 0;
		shift_n = 0;
		accepted = 0;
		got_r = '0;
		got_g = '0;
		got_b = '0;
		rng = 32'd83153;
		build_stimulus();

		repeat (4) @(posedge clk);
		#DRV_DELAY;
		rst = 1'b0;

		@(negedge clk);
		start_err = err_cnt;
		check_equal("reset_state", 0, col_clk);
		check_equal("reset_state", 0, col_latch);
		check_equal("reset_state", 0, led_oe);
		check_equal("reset_state", 0, row_addr);
		check_equal("reset_state", 1, pix_ready);
		report_test("reset_state", start_err);

		@(posedge clk);
		#DRV_DELAY;
		fork
			send_pixels();
		join_none

		for (int t = 0; t < NUM_TESTS; t++) begin
			start_err = err_cnt;
			wait (rows_done > t);
			// the address moves on the edge that ends the release cycle
			@(negedge clk);
			check_equal(tests[t].name, (tests[t].exp_row + 1) % `LP_ROWS, row_addr);
			report_test(tests[t].name, start_err);
		end

		$display("%0d tests passed, %0d tests failed, %0d assertion failures",
			pass_cnt, fail_cnt, dut0.props0.assert_fails);
		if (fail_cnt == 0 && err_cnt == 0 && dut0.props0.assert_fails == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: hdl/gamma_encoder.sv
`timescale 1ns/1ps
`include "led_panel_defines.svh"

module gamma_encoder (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  led_panel_pkg::channel_t in_r,
	input  led_panel_pkg::channel_t in_g,
	input  led_panel_pkg::channel_t in_b,
	output logic                  out_valid,
	input  logic                  out_ready,
	output led_panel_pkg::level_t out_r,
	output led_panel_pkg::level_t out_g,
	output led_panel_pkg::level_t out_b
);

	// number of table entries, one per possible input code
	localparam int DEPTH = 2 ** `LP_CHAN_BITS;
	// full-scale input code and full-scale PWM level
	localparam int CHAN_MAX = DEPTH - 1;
	localparam int LVL_MAX = led_panel_pkg::PWM_STEPS - 1;

	// the gamma rule: normalise, raise to the exponent, scale to the PWM range
	// $rtoi truncates toward zero, so only full scale reaches the top level
	function automatic led_panel_pkg::level_t gamma_level(input int x);
		real norm;
		real scaled;
		norm = real'(x) / real'(CHAN_MAX);
		scaled = (norm ** `LP_GAMMA) * real'(LVL_MAX);
		return led_panel_pkg::level_t'($rtoi(scaled));
	endfunction

	// one table per channel so that each colour could get its own curve later
	// for now all three hold the same values
	led_panel_pkg::level_t lut_r [DEPTH];
	led_panel_pkg::level_t lut_g [DEPTH];
	led_panel_pkg::level_t lut_b [DEPTH];

	// every entry is a constant worked out at elaboration
	for (genvar i = 0; i < DEPTH; i++) begin : g_lut
		localparam led_panel_pkg::level_t LVL = gamma_level(i);
		assign lut_r[i] = LVL;
		assign lut_g[i] = LVL;
		assign lut_b[i] = LVL;
	end

	// the output register can take a new pixel when it is empty
	// or when the buffer is taking its current contents on this edge
	// when the buffer stalls this goes low and stalls the pixel source
	assign in_ready = !out_valid || out_ready;

	// valid bit of the output register, cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// corrected levels, loaded together with the valid bit
	// when in_valid is low the loaded value is simply ignored downstream
	always_ff @(posedge clk) begin
		if (in_ready) begin
			out_r <= lut_r[in_r];
			out_g <= lut_g[in_g];
			out_b <= lut_b[in_b];
		end
	end

endmodule

// File: hdl/led_panel_defines.svh
`ifndef LED_PANEL_DEFINES_SVH
`define LED_PANEL_DEFINES_SVH

// width of one incoming colour channel, as delivered by the pixel source
`define LP_CHAN_BITS 8

// width of a corrected PWM level
// three bits give eight equal-weight steps per displayed row
`define LP_PWM_BITS 3

// number of columns shifted out per row and colour
`define LP_COLS 8

// number of row addresses on the panel
// the scan engine wraps back to row 0 after the last one
`define LP_ROWS 4

// exponent of the gamma curve, applied as a real when the tables are built
// 2.2 is a common match for the eye's response to LED brightness
`define LP_GAMMA 2.2

`endif

// File: hdl/led_panel_driver.sv
`timescale 1ns/1ps

module led_panel_driver (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    pix_valid,
	output logic                    pix_ready,
	input  led_panel_pkg::channel_t pix_r,
	input  led_panel_pkg::channel_t pix_g,
	input  led_panel_pkg::channel_t pix_b,
	output led_panel_pkg::row_t     row_addr,
	output logic                    col_r,
	output logic                    col_g,
	output logic                    col_b,
	output logic                    col_clk,
	output logic                    col_latch,
	output logic                    led_oe
);

	// corrected pixel stream from the encoder into the line buffer
	logic lvl_valid;
	logic lvl_ready;
	led_panel_pkg::level_t lvl_r;
	led_panel_pkg::level_t lvl_g;
	led_panel_pkg::level_t lvl_b;

	// buffer status and read port toward the scan engine
	logic row_full;
	logic row_release;
	led_panel_pkg::col_t rd_col;
	led_panel_pkg::level_t rd_r;
	led_panel_pkg::level_t rd_g;
	led_panel_pkg::level_t rd_b;

	// gamma correction, one pixel per handshake
	gamma_encoder u_gamma (
		.clk(clk), .rst(rst),
		.in_valid(pix_valid), .in_ready(pix_ready),
		.in_r(pix_r), .in_g(pix_g), .in_b(pix_b),
		.out_valid(lvl_valid), .out_ready(lvl_ready),
		.out_r(lvl_r), .out_g(lvl_g), .out_b(lvl_b)
	);

	// holds one row; its full flag is the back-pressure source
	line_buffer u_buf (
		.clk(clk), .rst(rst),
		.wr_valid(lvl_valid), .wr_ready(lvl_ready),
		.wr_r(lvl_r), .wr_g(lvl_g), .wr_b(lvl_b),
		.row_full(row_full),
		.rd_col(rd_col), .rd_r(rd_r), .rd_g(rd_g), .rd_b(rd_b),
		.row_release(row_release)
	);

	// PWM row display onto the panel pins
	pwm_scan_engine u_scan (
		.clk(clk), .rst(rst),
		.row_full(row_full),
		.rd_col(rd_col), .rd_r(rd_r), .rd_g(rd_g), .rd_b(rd_b),
		.row_release(row_release), .row_addr(row_addr),
		.col_r(col_r), .col_g(col_g), .col_b(col_b),
		.col_clk(col_clk), .col_latch(col_latch), .led_oe(led_oe)
	);

endmodule

// File: hdl/led_panel_pkg.sv
`include "led_panel_defines.svh"

package led_panel_pkg;

	// one raw colour channel of an incoming pixel
	typedef logic [`LP_CHAN_BITS-1:0] channel_t;

	// one gamma-corrected PWM level
	// a column is lit in step k when its level is greater than k
	typedef logic [`LP_PWM_BITS-1:0] level_t;

	// index of a column within a row, used for buffer writes and reads
	typedef logic [$clog2(`LP_COLS)-1:0] col_t;

	// address of the row currently driven onto the panel
	typedef logic [$clog2(`LP_ROWS)-1:0] row_t;

	// number of PWM steps in one row display
	// the highest level is one less than this
	localparam int PWM_STEPS = 2 ** `LP_PWM_BITS;

endpackage

// File: hdl/line_buffer.sv
`timescale 1ns/1ps
`include "led_panel_defines.svh"

module line_buffer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  wr_valid,
	output logic                  wr_ready,
	input  led_panel_pkg::level_t wr_r,
	input  led_panel_pkg::level_t wr_g,
	input  led_panel_pkg::level_t wr_b,
	output logic                  row_full,
	input  led_panel_pkg::col_t   rd_col,
	output led_panel_pkg::level_t rd_r,
	output led_panel_pkg::level_t rd_g,
	output led_panel_pkg::level_t rd_b,
	input  logic                  row_release
);

	// index of the last column in a row
	localparam led_panel_pkg::col_t LAST_COL = led_panel_pkg::col_t'(`LP_COLS - 1);

	// one corrected level per column and colour
	led_panel_pkg::level_t mem_r [`LP_COLS];
	led_panel_pkg::level_t mem_g [`LP_COLS];
	led_panel_pkg::level_t mem_b [`LP_COLS];

	// column that the next write goes to
	led_panel_pkg::col_t wr_idx;

	logic wr_fire;

	// no second buffer, so writes stop while the row is on display
	assign wr_ready = !row_full;
	assign wr_fire = wr_valid && wr_ready;

	// write index and full flag
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_idx <= '0;
			row_full <= 1'b0;
		end else if (row_release) begin
			// the scan engine is done, so the row may be refilled from column 0
			wr_idx <= '0;
			row_full <= 1'b0;
		end else if (wr_fire) begin
			if (wr_idx == LAST_COL) begin
				wr_idx <= '0;
				row_full <= 1'b1;
			end else begin
				wr_idx <= wr_idx + 1'b1;
			end
		end
	end

	// storage, written on the handshake edge
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			mem_r[wr_idx] <= wr_r;
			mem_g[wr_idx] <= wr_g;
			mem_b[wr_idx] <= wr_b;
		end
	end

	// reads are combinational so the scan engine sees the level in the same cycle
	assign rd_r = mem_r[rd_col];
	assign rd_g = mem_g[rd_col];
	assign rd_b = mem_b[rd_col];

endmodule

// File: hdl/pwm_scan_engine.sv
`timescale 1ns/1ps
`include "led_panel_defines.svh"

module pwm_scan_engine (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  row_full,
	output led_panel_pkg::col_t   rd_col,
	input  led_panel_pkg::level_t rd_r,
	input  led_panel_pkg::level_t rd_g,
	input  led_panel_pkg::level_t rd_b,
	output logic                  row_release,
	output led_panel_pkg::row_t   row_addr,
	output logic                  col_r,
	output logic                  col_g,
	output logic                  col_b,
	output logic                  col_clk,
	output logic                  col_latch,
	output logic                  led_oe
);

	// last column of a row and last PWM step of a row
	localparam led_panel_pkg::col_t LAST_COL = led_panel_pkg::col_t'(`LP_COLS - 1);
	localparam led_panel_pkg::level_t LAST_STEP =
		led_panel_pkg::level_t'(led_panel_pkg::PWM_STEPS - 1);
	// highest row address before wrapping back to 0
	localparam led_panel_pkg::row_t LAST_ROW = led_panel_pkg::row_t'(`LP_ROWS - 1);

	// idle waits for a full row, shift clocks out one column per cycle,
	// latch transfers the shifted bits to the panel drivers
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_LATCH
	} state_t;

	state_t state;

	// column being shifted and PWM step being shown
	led_panel_pkg::col_t col_cnt;
	led_panel_pkg::level_t step_cnt;

	// output enable, kept in a register so it changes on clean edges
	logic oe_q;

	// the buffer is addressed by the shift counter directly
	assign rd_col = col_cnt;

	// one panel clock per shifted column, data valid in the same cycle
	assign col_clk = (state == ST_SHIFT);
	assign col_latch = (state == ST_LATCH);

	// equal-weight PWM: a column is lit in step k when its level exceeds k
	// the bits are held low outside the shift state to keep the data pins quiet
	assign col_r = col_clk && (rd_r > step_cnt);
	assign col_g = col_clk && (rd_g > step_cnt);
	assign col_b = col_clk && (rd_b > step_cnt);

	// the row is handed back during the latch of the final step
	// the buffer then clears row_full on the same edge that returns us to idle
	assign row_release = (state == ST_LATCH) && (step_cnt == LAST_STEP);

	assign led_oe = oe_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			col_cnt <= '0;
			step_cnt <= '0;
			row_addr <= '0;
			oe_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					// start shifting step 0 once the buffer holds a whole row
					if (row_full) begin
						state <= ST_SHIFT;
						col_cnt <= '0;
						step_cnt <= '0;
					end
				end

				ST_SHIFT: begin
					if (col_cnt == LAST_COL) begin
						state <= ST_LATCH;
						col_cnt <= '0;
						// LEDs come on together with the first latch of the row
						if (step_cnt == '0) begin
							oe_q <= 1'b1;
						end
						// and go dark for the release cycle at the end
						if (step_cnt == LAST_STEP) begin
							oe_q <= 1'b0;
						end
					end else begin
						col_cnt <= col_cnt + 1'b1;
					end
				end

				ST_LATCH: begin
					if (step_cnt == LAST_STEP) begin
						// row finished, move to the next row address
						state <= ST_IDLE;
						step_cnt <= '0;
						if (row_addr == LAST_ROW) begin
							row_addr <= '0;
						end else begin
							row_addr <= row_addr + 1'b1;
						end
					end else begin
						state <= ST_SHIFT;
						step_cnt <= step_cnt + 1'b1;
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: verilog.f
+incdir+hdl
hdl/led_panel_pkg.sv
hdl/gamma_encoder.sv
hdl/line_buffer.sv
hdl/pwm_scan_engine.sv
hdl/led_panel_driver.sv
dv/led_panel_props.sv
dv/led_panel_tb.sv
